// ==== files.f ====
+incdir+include
source/gc_pkg.sv
source/n_serial_io_buffer.sv
source/n_serial_rx.sv
source/n_serial_tx.sv
source/gc_controller.sv
source/gc_emulator.sv
verification/gc_assert.sv
verification/gc_tb.sv

// ==== Makefile ====
# Verilator build for the GameCube controller emulator

OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module gc_tb
	verilator --lint-only -Wall -Iinclude source/gc_pkg.sv source/n_serial_io_buffer.sv \
		source/n_serial_rx.sv source/n_serial_tx.sv source/gc_controller.sv \
		source/gc_emulator.sv --top-module gc_emulator

sim:
	verilator --binary --timing --assert -f files.f --top-module gc_tb -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vgc_tb > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/gc_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module gc_tb;

	// One quarter is 25 cycles, a bit is four quarters
	localparam int QUARTER = 25;
	localparam int BIT = 4 * QUARTER;
	// Bit period in simulation time, the clock period being 10 ns
	localparam int BIT_NS = BIT * 10;
	// First reply edge comes after the idle gap and a few cycles of latency
	localparam int REPLY_LIMIT = 10 * BIT;

	logic clk;
	logic reset;
	// Console side of the open-drain line
	logic console_low;
	logic gc_line;
	logic gc_drive_low;
	gc_pkg::gc_status_t controller_state;
	logic rumble;
	logic [31:0] lfsr_state;

	// The wired line is low whenever the console or the controller pulls it
	assign gc_line = ~(console_low | gc_drive_low);

	gc_emulator u_gc_emulator (
		.clk(clk),
		.reset(reset),
		.gc_line(gc_line),
		.gc_drive_low(gc_drive_low),
		.controller_state(controller_state),
		.rumble(rumble)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
		end
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// One LFSR step for each bit drawn
	task automatic draw_bits(input int count, output logic [63:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[62:0], lfsr_state[0]};
		end
	endtask

	// Starts on a rising edge and ends on one, one bit time later
	// A 1 is one quarter low, a 0 is three quarters low
	task automatic send_bit(input logic value);
		int low_q;
		low_q = value ? 1 : 3;
		console_low <= 1'b1;
		repeat (low_q * QUARTER) @(posedge clk);
		console_low <= 1'b0;
		repeat ((4 - low_q) * QUARTER) @(posedge clk);
	endtask

	task automatic send_byte(input logic [7:0] value);
		for (int i = 7; i >= 0; i--) begin
			send_bit(value[i]);
		end
	endtask

	task automatic send_stop();
		send_bit(1'b1);
	endtask

	// Bytes are taken from the top of the word, first byte first
	task automatic send_command(input logic [23:0] bytes, input int count);
		@(posedge clk);
		for (int i = 0; i < count; i++) begin
			send_byte(bytes[23 - 8 * i -: 8]);
		end
		send_stop();
	endtask

	// Outputs are sampled on the falling edge, clear of the register updates
	task automatic wait_drive(input logic level, input int limit, input string what);
		int n;
		n = 0;
		@(negedge clk);
		while (gc_drive_low !== level) begin
			n++;
			if (n > limit) begin
				abort_run($sformatf("Timed out waiting for %s", what));
			end
			@(negedge clk);
		end
	endtask

	// Midpoint of the bit decides, drive still active there means a 0
	task automatic recv_bit(input int limit, output logic value, output time rise);
		wait_drive(1'b1, limit, "the start of a response bit");
		rise = $time;
		repeat (2 * QUARTER) @(negedge clk);
		value = ~gc_drive_low;
		wait_drive(1'b0, 2 * QUARTER, "the end of a response bit");
	endtask

	task automatic recv_byte(input int limit, output logic [7:0] value);
		logic b;
		time rise;
		time prev_rise;
		prev_rise = 0;
		for (int i = 7; i >= 0; i--) begin
			recv_bit((i == 7) ? limit : BIT, b, rise);
			// Bits inside a byte follow each other at exactly one bit time
			if (i != 7) begin
				check("response bit period", BIT_NS, rise - prev_rise);
			end
			prev_rise = rise;
			value[i] = b;
		end
	endtask

	task automatic expect_quiet(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			if (gc_drive_low !== 1'b0) begin
				abort_run($sformatf("%s: the controller drove the line when it should not", name));
			end
		end
	endtask

	// The quiet time also lets the receiver's echo frame of the reply run out
	task automatic recv_stop(input string name);
		logic b;
		time rise;
		recv_bit(BIT, b, rise);
		check({name, " stop bit"}, 1, b);
		expect_quiet({name, " after stop"}, 3 * BIT);
	endtask

	// Optionally flips the status input once the reply is under way, which must not matter
	task automatic recv_reply(input string name, input logic [63:0] expected, input int count,
		input logic change_state);
		logic [7:0] got;
		for (int i = 0; i < count; i++) begin
			recv_byte((i == 0) ? REPLY_LIMIT : BIT, got);
			check($sformatf("%s byte %0d", name, i), expected[63 - 8 * i -: 8], got);
			if (i == 0 && change_state) begin
				@(posedge clk);
				controller_state <= ~controller_state;
			end
		end
		recv_stop(name);
	endtask

	task automatic poll(input string name, input logic [63:0] status, input logic flag);
		@(posedge clk);
		controller_state <= status;
		send_command({8'h40, 8'h03, 7'h00, flag}, 3);
		recv_reply(name, status, 8, 1'b1);
		check({name, " rumble"}, flag, rumble);
	endtask

	// held is the rumble level left by the last valid poll
	task automatic bad_command(input string name, input logic [23:0] bytes, input int count,
		input logic held);
		send_command(bytes, count);
		// Covers the idle gap before the stop and three bit times after it
		expect_quiet(name, 4 * BIT);
		check({name, " rumble"}, held, rumble);
	endtask

	task automatic test_reset_idle();
		check("reset drive", 0, gc_drive_low);
		check("reset rumble", 0, rumble);
		expect_quiet("idle after reset", BIT);
		check("idle rumble", 0, rumble);
	endtask

	task automatic test_id();
		send_command({8'h00, 16'h0000}, 1);
		recv_reply("id reply", {24'h090000, 40'h0}, 3, 1'b0);
	endtask

	task automatic test_poll_rumble();
		poll("poll flags 1", 64'h1234_8091_7f80_a5c3, 1'b1);
		poll("poll flags 0", 64'hfedc_2345_6789_0abc, 1'b0);
	endtask

	// Rumble is set first, so a wrong update by a bad command would show
	task automatic test_malformed();
		poll("poll before bad commands", 64'h0f0f_55aa_8080_1020, 1'b1);
		bad_command("wrong second byte", {8'h40, 8'h05, 8'h00}, 3, 1'b1);
		bad_command("unknown first byte", {8'h12, 16'h0000}, 1, 1'b1);
		bad_command("missing flags byte", {8'h40, 8'h03, 8'h00}, 2, 1'b1);
	endtask

	task automatic test_random_polls();
		logic [63:0] status;
		logic [63:0] flag;
		for (int i = 0; i < 5; i++) begin
			draw_bits(64, status);
			draw_bits(1, flag);
			poll($sformatf("random poll %0d", i), status, flag[0]);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		console_low = 1'b0;
		controller_state = '0;
		lfsr_state = 32'h7842_e47e;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		test_reset_idle();
		test_id();
		test_poll_rumble();
		test_malformed();
		test_random_polls();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/gc_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module gc_assert (
	input logic clk,
	input logic reset,
	input gc_pkg::rx_event_t rx_event,
	input logic busy,
	input gc_pkg::tx_req_t tx_req,
	input logic rumble
);

	// The transmitter only loads while idle, so a strobe during busy would drop a byte
	a_strobe_not_busy: assert property (@(posedge clk) disable iff (reset)
		!(tx_req.strobe && busy))
		else $error("transmit strobe raised while the transmitter is busy");

	// Every request is a single-cycle pulse
	a_strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
		tx_req.strobe |=> !tx_req.strobe)
		else $error("transmit strobe held for more than one cycle");

	// Rumble may only follow the stop event of a complete poll
	a_rumble_on_stop: assert property (@(posedge clk) disable iff (reset)
		(rumble != $past(rumble)) |-> $past(rx_event.stop))
		else $error("rumble changed without a stop event in the previous cycle");

endmodule

// Attach the checks to every controller instance
bind gc_controller gc_assert u_gc_assert (
	.clk(clk),
	.reset(reset),
	.rx_event(rx_event),
	.busy(busy),
	.tx_req(tx_req),
	.rumble(rumble)
);

`default_nettype wire

// ==== source/gc_emulator.sv ====
`timescale 1ns/1ns
`default_nettype none

module gc_emulator (
	input logic clk,
	input logic reset,
	input logic gc_line,
	output logic gc_drive_low,
	input gc_pkg::gc_status_t controller_state,
	output logic rumble
);

	// Synchronized line level and the transmit level before the buffer
	logic rx;
	logic tx;
	logic busy;
	gc_pkg::rx_event_t rx_event;
	gc_pkg::tx_req_t tx_req;

	// The receiver also hears the controller's own replies on the shared line
	// The controller ignores those events while it is sending
	n_serial_io_buffer u_io_buffer (
		.clk(clk),
		.reset(reset),
		.line(gc_line),
		.tx(tx),
		.rx(rx),
		.drive_low(gc_drive_low)
	);

	n_serial_rx u_rx (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.rx_event(rx_event)
	);

	n_serial_tx u_tx (
		.clk(clk),
		.reset(reset),
		.tx_req(tx_req),
		.busy(busy),
		.tx(tx)
	);

	gc_controller u_controller (
		.clk(clk),
		.reset(reset),
		.rx_event(rx_event),
		.busy(busy),
		.tx_req(tx_req),
		.controller_state(controller_state),
		.rumble(rumble)
	);

endmodule

`default_nettype wire

// ==== source/gc_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gc_defines.svh"

module gc_controller (
	input logic clk,
	input logic reset,
	input gc_pkg::rx_event_t rx_event,
	input logic busy,
	output gc_pkg::tx_req_t tx_req,
	input gc_pkg::gc_status_t controller_state,
	output logic rumble
);

	localparam logic [3:0] S_IDLE = 4'd0;
	localparam logic [3:0] S_RX_CMD_0 = 4'd1;
	localparam logic [3:0] S_RX_POLL_1 = 4'd2;
	localparam logic [3:0] S_RX_POLL_2 = 4'd3;
	localparam logic [3:0] S_FINISH_ID = 4'd4;
	localparam logic [3:0] S_FINISH_POLL = 4'd5;
	localparam logic [3:0] S_SEND = 4'd6;
	localparam logic [3:0] S_SEND_WAIT = 4'd7;
	localparam logic [3:0] S_STOP_BIT = 4'd8;

	logic [3:0] state;
	// Bytes still to send in the current response
	logic [3:0] byte_cnt;
	// Response bytes, the next one to send is in the top byte
	logic [63:0] resp;
	gc_pkg::gc_cmd_u cmd;

	logic frame_abort;
	logic finish_ok;
	logic load_id;
	logic load_poll;
	logic send_byte;

	// Anything but a stop after the last command byte spoils the frame
	assign frame_abort = rx_event.start || rx_event.error || rx_event.strobe;
	assign finish_ok = rx_event.stop && !frame_abort;

	// The ID request needs no further checks once its byte matched
	assign load_id = (state == S_FINISH_ID) && finish_ok;
	// The poll needs both fixed bytes, the flags byte is free
	assign load_poll = (state == S_FINISH_POLL) && finish_ok &&
		(cmd.raw[0] == `GC_CMD_POLL_0) && (cmd.raw[1] == `GC_CMD_POLL_1);

	assign send_byte = (state == S_SEND) && !busy;

	// Requests come straight from the state, so the first strobe follows the stop
	// by one cycle and each strobe lasts a single cycle
	always_comb begin
		tx_req = '0;
		tx_req.data = resp[63:56];
		tx_req.stopbit = (state == S_STOP_BIT);
		tx_req.strobe = send_byte || ((state == S_STOP_BIT) && !busy);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= S_IDLE;
			byte_cnt <= '0;
			rumble <= 1'b0;
		end else begin
			case (state)
				// Wait for the console to open a frame
				S_IDLE: begin
					if (rx_event.start) begin
						state <= S_RX_CMD_0;
					end
				end

				// First byte decides which command this is
				S_RX_CMD_0: begin
					if (rx_event.stop || rx_event.start || rx_event.error) begin
						state <= S_IDLE;
					end else if (rx_event.strobe) begin
						if (rx_event.data == `GC_CMD_ID) begin
							state <= S_FINISH_ID;
						end else if (rx_event.data == `GC_CMD_POLL_0) begin
							state <= S_RX_POLL_1;
						end else begin
							state <= S_IDLE;
						end
					end
				end

				// Second poll byte, checked once the frame is complete
				S_RX_POLL_1: begin
					if (rx_event.stop || rx_event.start || rx_event.error) begin
						state <= S_IDLE;
					end else if (rx_event.strobe) begin
						state <= S_RX_POLL_2;
					end
				end

				// Flags byte
				S_RX_POLL_2: begin
					if (rx_event.stop || rx_event.start || rx_event.error) begin
						state <= S_IDLE;
					end else if (rx_event.strobe) begin
						state <= S_FINISH_POLL;
					end
				end

				S_FINISH_ID: begin
					if (frame_abort) begin
						state <= S_IDLE;
					end else if (load_id) begin
						byte_cnt <= 4'(`GC_ID_BYTES);
						state <= S_SEND;
					end
				end

				// Rumble only follows a poll that arrived whole and valid
				S_FINISH_POLL: begin
					if (load_poll) begin
						rumble <= cmd.poll.flags[0];
						byte_cnt <= 4'(`GC_STATUS_BYTES);
						state <= S_SEND;
					end else if (frame_abort || rx_event.stop) begin
						state <= S_IDLE;
					end
				end

				S_SEND: begin
					if (send_byte) begin
						byte_cnt <= byte_cnt - 1'b1;
						state <= S_SEND_WAIT;
					end
				end

				// busy only rises the cycle after a strobe, so skip a cycle
				S_SEND_WAIT: begin
					if (byte_cnt == 4'd0) begin
						state <= S_STOP_BIT;
					end else begin
						state <= S_SEND;
					end
				end

				// The stop bit closes the response
				S_STOP_BIT: begin
					if (!busy) begin
						state <= S_IDLE;
					end
				end

				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Command bytes land in the word by arrival position
	always_ff @(posedge clk) begin
		if (rx_event.strobe) begin
			case (state)
				S_RX_CMD_0: cmd.raw[0] <= rx_event.data;
				S_RX_POLL_1: cmd.raw[1] <= rx_event.data;
				S_RX_POLL_2: cmd.raw[2] <= rx_event.data;
				default: cmd <= cmd;
			endcase
		end
	end

	// The status is captured at the stop, so later input changes do not tear
	// the response in the middle of sending it
	always_ff @(posedge clk) begin
		if (load_id) begin
			resp <= {`GC_CONTROLLER_ID, 40'h0};
		end else if (load_poll) begin
			resp <= controller_state;
		end else if (send_byte) begin
			resp <= {resp[55:0], 8'h00};
		end
	end

endmodule

`default_nettype wire

// ==== source/n_serial_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gc_defines.svh"

module n_serial_tx (
	input logic clk,
	input logic reset,
	input gc_pkg::tx_req_t tx_req,
	output logic busy,
	output logic tx
);

	localparam int QW = $clog2(`GC_QUARTER_CYCLES);

	// Cycles within the current quarter
	logic [QW-1:0] quarter_cnt;
	// Quarter within the current bit, wraps from 3 back to 0
	logic [1:0] quarter;
	logic [3:0] bits_left;
	// Bit being sent sits in the top position
	logic [7:0] shift;

	logic quarter_done;
	logic bit_done;
	logic load;

	assign quarter_done = quarter_cnt == QW'(`GC_QUARTER_CYCLES - 1);
	assign bit_done = quarter_done && (quarter == 2'd3);
	assign load = tx_req.strobe && !busy;

	// Every bit starts low and ends high
	// A 0 bit also keeps the middle two quarters low
	assign tx = ~(busy && (quarter == 2'd0 || (quarter != 2'd3 && !shift[7])));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			quarter_cnt <= '0;
			quarter <= '0;
			bits_left <= '0;
		end else if (!busy) begin
			// A stop request is just a single 1 bit
			if (load) begin
				busy <= 1'b1;
				quarter_cnt <= '0;
				quarter <= '0;
				bits_left <= tx_req.stopbit ? 4'd1 : 4'd8;
			end
		end else if (quarter_done) begin
			quarter_cnt <= '0;
			quarter <= quarter + 1'b1;
			if (bit_done) begin
				bits_left <= bits_left - 1'b1;
				// Last quarter of the last bit is out, the next request may load
				if (bits_left == 4'd1) begin
					busy <= 1'b0;
				end
			end
		end else begin
			quarter_cnt <= quarter_cnt + 1'b1;
		end
	end

	// Payload shifter
	// An all-ones load makes the stop bit a 1 wherever it is read
	always_ff @(posedge clk) begin
		if (load) begin
			shift <= tx_req.stopbit ? 8'hff : tx_req.data;
		end else if (busy && bit_done) begin
			shift <= {shift[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// ==== source/n_serial_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "gc_defines.svh"

module n_serial_rx (
	input logic clk,
	input logic reset,
	input logic rx,
	output gc_pkg::rx_event_t rx_event
);

	// Wide enough for the idle gap, which is the longest interval measured
	localparam int CW = $clog2(`GC_STOP_GAP_CYCLES + 1);

	logic rx_prev;
	logic [CW-1:0] low_cnt;
	logic [CW-1:0] high_cnt;
	// Set once the line has been high for a full gap
	logic idle;
	// Set while a frame is being decoded without error
	logic active;
	// The first bit of the current byte was a 1, so it may be a stop bit
	logic stop_cand;
	logic [2:0] bit_cnt;
	logic [7:0] shift;

	logic falling;
	logic rising;
	logic bit_value;
	logic [7:0] next_shift;
	logic too_long;
	logic gap_reached;

	assign falling = rx_prev & ~rx;
	assign rising = ~rx_prev & rx;

	// At a rising edge low_cnt holds the width of the pulse that just ended
	// Under two quarters is a 1, anything longer that got this far is a 0
	assign bit_value = low_cnt < CW'(2 * `GC_QUARTER_CYCLES);
	assign next_shift = {shift[6:0], bit_value};

	// The low pulse is about to run past four quarters
	assign too_long = ~rx & ~falling & active & (low_cnt == CW'(4 * `GC_QUARTER_CYCLES));

	// The line has stayed high long enough after the last bit to end the frame
	assign gap_reached = rx & ~rising & ~idle & (high_cnt == CW'(`GC_STOP_GAP_CYCLES));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rx_prev <= 1'b1;
			low_cnt <= '0;
			high_cnt <= '0;
			idle <= 1'b1;
			active <= 1'b0;
			stop_cand <= 1'b0;
			bit_cnt <= '0;
			rx_event <= '0;
		end else begin
			rx_prev <= rx;

			// Events are pulses, so they drop again unless set below
			rx_event.start <= 1'b0;
			rx_event.stop <= 1'b0;
			rx_event.error <= 1'b0;
			rx_event.strobe <= 1'b0;

			// Pulse width counters, both saturate so a stuck line cannot wrap them
			if (falling) begin
				low_cnt <= CW'(1);
			end else if (~rx && low_cnt != '1) begin
				low_cnt <= low_cnt + 1'b1;
			end
			if (rising) begin
				high_cnt <= CW'(1);
			end else if (rx && high_cnt != '1) begin
				high_cnt <= high_cnt + 1'b1;
			end

			// Only the first falling edge after idle opens a frame
			if (falling && idle) begin
				rx_event.start <= 1'b1;
				idle <= 1'b0;
				active <= 1'b1;
				bit_cnt <= '0;
				stop_cand <= 1'b0;
			end

			// A pulse this long is no valid bit, drop the rest of the frame
			if (too_long) begin
				rx_event.error <= 1'b1;
				active <= 1'b0;
			end

			// Every completed pulse is one bit, eight make a byte
			if (rising && active) begin
				bit_cnt <= bit_cnt + 1'b1;
				stop_cand <= (bit_cnt == 3'd0) && bit_value;
				if (bit_cnt == 3'd7) begin
					rx_event.strobe <= 1'b1;
					rx_event.data <= next_shift;
				end
			end

			// End of frame
			// Only a lone 1 bit after whole bytes counts as a stop
			if (gap_reached) begin
				idle <= 1'b1;
				active <= 1'b0;
				if (active) begin
					if (bit_cnt == 3'd1 && stop_cand) begin
						rx_event.stop <= 1'b1;
					end else begin
						rx_event.error <= 1'b1;
					end
				end
			end
		end
	end

	// Bits arrive most significant first
	always_ff @(posedge clk) begin
		if (rising && active) begin
			shift <= next_shift;
		end
	end

endmodule

`default_nettype wire

// ==== source/n_serial_io_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module n_serial_io_buffer (
	input logic clk,
	input logic reset,
	input logic line,
	input logic tx,
	output logic rx,
	output logic drive_low
);

	// First synchronizer stage, may go metastable
	logic line_meta;

	// Two flops bring the asynchronous line into the clock domain
	// The idle level of the bus is high, so reset parks both stages there
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			line_meta <= 1'b1;
			rx <= 1'b1;
		end else begin
			line_meta <= line;
			rx <= line_meta;
		end
	end

	// The line is open drain, so a low transmit level becomes a pull-low enable
	// Registering it keeps combinational hazards in the transmitter off the pin
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			drive_low <= 1'b0;
		end else begin
			drive_low <= ~tx;
		end
	end

endmodule

`default_nettype wire

// ==== source/gc_pkg.sv ====
`default_nettype none

package gc_pkg;

	// Controller status word, sent from the top byte down
	// The first two bytes hold the buttons, then the analog axes follow
	typedef struct packed {
		logic [15:0] buttons;
		logic [7:0] stick_x;
		logic [7:0] stick_y;
		logic [7:0] cstick_x;
		logic [7:0] cstick_y;
		logic [7:0] trigger_l;
		logic [7:0] trigger_r;
	} gc_status_t;

	// Receiver events, each one a single-cycle pulse
	// data is only meaningful in the cycle where strobe is high
	typedef struct packed {
		logic start;
		logic stop;
		logic error;
		logic strobe;
		logic [7:0] data;
	} rx_event_t;

	// Transmitter request
	// With stopbit set the data byte is ignored and a lone 1 bit goes out
	typedef struct packed {
		logic strobe;
		logic stopbit;
		logic [7:0] data;
	} tx_req_t;

	// Poll command fields in the order they arrive on the line
	typedef struct packed {
		logic [7:0] cmd;
		logic [7:0] sub;
		logic [7:0] flags;
	} gc_poll_t;

	// Received command word
	// The raw view is indexed by arrival order, so raw[0] lines up with poll.cmd
	typedef union packed {
		logic [0:2][7:0] raw;
		gc_poll_t poll;
	} gc_cmd_u;

endpackage

`default_nettype wire

// ==== include/gc_defines.svh ====
`ifndef GC_DEFINES_SVH
`define GC_DEFINES_SVH

// Bit timing on the console line
// One bit is four quarters, so with 25 cycles per quarter a bit is 100 cycles
`define GC_QUARTER_CYCLES 25

// High time after a rising edge beyond which the line counts as idle
// Normal bits stay high for at most three quarters, so six is well clear of that
`define GC_STOP_GAP_CYCLES (6 * `GC_QUARTER_CYCLES)

// Command bytes sent by the console
// The identification request is a single byte
`define GC_CMD_ID 8'h00
// The poll command is two fixed bytes followed by a flags byte
`define GC_CMD_POLL_0 8'h40
`define GC_CMD_POLL_1 8'h03

// ID of a standard controller, sent most significant byte first
`define GC_CONTROLLER_ID 24'h090000

// Response lengths in bytes, not counting the closing stop bit
`define GC_ID_BYTES 3
`define GC_STATUS_BYTES 8

`endif
